/* verilog/hdc_pkg.sv */
package hdc_pkg;

    // defaults only, the top level passes the real values down
    localparam int HV_BITS_DEF    = 256;
    localparam int ITEM_DEPTH_DEF = 64;
    localparam int MAX_SYMBOLS    = 8;
    localparam int ITEM_ADDR_BITS = $clog2(ITEM_DEPTH_DEF);
    // a 256 byte window holds 64 words
    localparam int WORD_IDX_BITS  = 6;

    typedef logic [ITEM_ADDR_BITS-1:0]      item_addr_t;
    typedef logic [$clog2(MAX_SYMBOLS)-1:0] slot_t;
    typedef logic [$clog2(MAX_SYMBOLS)-1:0] rot_t;
    // length 1..MAX_SYMBOLS needs one bit more than a slot
    typedef logic [$clog2(MAX_SYMBOLS):0]   len_t;
    typedef logic [31:0]                    word_t;
    typedef logic [WORD_IDX_BITS-1:0]       word_idx_t;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        FETCH,
        BIND,
        ACCUM,
        STORE
    } seq_state_t;

    // one step per cycle, sequencer to core
    typedef struct packed {
        logic clear;
        logic bind_op;
        logic accum;
        logic store;
        rot_t rot;
    } core_cmd_t;

    // apb register map
    localparam logic [11:0] ADDR_CTRL        = 12'h000;
    localparam logic [11:0] ADDR_STATUS      = 12'h004;
    localparam logic [11:0] ADDR_LEN         = 12'h008;
    localparam logic [11:0] ADDR_ITEM_ADDR   = 12'h00C;
    localparam logic [11:0] ADDR_ITEM_COMMIT = 12'h010;
    localparam logic [11:0] ADDR_SEQ_BASE    = 12'h020;
    localparam logic [11:0] ADDR_STAGE_BASE  = 12'h100;
    localparam logic [11:0] ADDR_RESULT_BASE = 12'h200;

    // ctrl bits
    localparam int CTRL_START_BIT = 0;
    localparam int CTRL_CLEAR_BIT = 1;

endpackage

/* verilog/hdc_apb_regs.sv */
module hdc_apb_regs #(
    parameter int HV_BITS = hdc_pkg::HV_BITS_DEF
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                psel,
    input  logic                penable,
    input  logic                pwrite,
    input  logic [11:0]         paddr,
    input  hdc_pkg::word_t      pwdata,
    output hdc_pkg::word_t      prdata,
    output logic                pready,
    output logic                pslverr,
    input  logic                busy,
    output logic                start,
    output logic                clear,
    output hdc_pkg::len_t       len,
    input  hdc_pkg::slot_t      slot,
    output hdc_pkg::item_addr_t seq_addr,
    output logic                item_we,
    output hdc_pkg::item_addr_t item_waddr,
    output logic [HV_BITS-1:0]  item_wdata,
    input  logic [HV_BITS-1:0]  result
);
    import hdc_pkg::*;

    localparam int HV_WORDS = HV_BITS / 32;

    len_t                 len_q;
    item_addr_t           item_addr_q;
    item_addr_t           seq_q [MAX_SYMBOLS];
    word_t [HV_WORDS-1:0] stage_q;
    word_t [HV_WORDS-1:0] result_words;
    // previous busy, for the done edge
    logic                 busy_q;
    logic                 done_q;

    logic      access;
    logic      wr;
    word_idx_t widx;
    slot_t     sidx;
    logic      hit_ctrl;
    logic      hit_status;
    logic      hit_len;
    logic      hit_iaddr;
    logic      hit_commit;
    logic      hit_seq;
    logic      hit_stage;
    logic      hit_result;
    logic      mapped;
    logic      start_req;
    logic      commit_req;
    logic      refused;

    // zero wait states, every access ends in its access cycle
    assign access = psel & penable;
    assign wr     = access & pwrite;
    assign widx   = paddr[2 +: WORD_IDX_BITS];
    assign sidx   = paddr[2 +: $bits(slot_t)];

    assign hit_ctrl   = (paddr == ADDR_CTRL);
    assign hit_status = (paddr == ADDR_STATUS);
    assign hit_len    = (paddr == ADDR_LEN);
    assign hit_iaddr  = (paddr == ADDR_ITEM_ADDR);
    assign hit_commit = (paddr == ADDR_ITEM_COMMIT);
    // 8 slots fill 0x020..0x03c
    assign hit_seq    = (paddr[11:5] == ADDR_SEQ_BASE[11:5]) && (paddr[1:0] == 2'b00);
    // only words that exist in the hypervector are mapped
    assign hit_stage  = (paddr[11:8] == ADDR_STAGE_BASE[11:8]) && (paddr[1:0] == 2'b00)
                        && (int'(widx) < HV_WORDS);
    assign hit_result = (paddr[11:8] == ADDR_RESULT_BASE[11:8]) && (paddr[1:0] == 2'b00)
                        && (int'(widx) < HV_WORDS);
    assign mapped     = hit_ctrl | hit_status | hit_len | hit_iaddr | hit_commit
                        | hit_seq | hit_stage | hit_result;

    assign start_req  = wr & hit_ctrl & pwdata[CTRL_START_BIT];
    assign commit_req = wr & hit_commit;
    // start or commit during a job is refused
    assign refused    = busy & (start_req | commit_req);

    assign pready  = 1'b1;
    assign pslverr = access & (~mapped | refused);

    // single cycle pulses straight off the access cycle
    assign start   = start_req & ~busy;
    assign clear   = start & pwdata[CTRL_CLEAR_BIT];
    assign item_we = commit_req & ~busy;

    assign item_waddr   = item_addr_q;
    assign item_wdata   = stage_q;
    assign len          = len_q;
    assign seq_addr     = seq_q[slot];
    assign result_words = result;

    always_ff @(posedge clk) begin
        if (reset) begin
            len_q       <= len_t'(1);
            item_addr_q <= '0;
            busy_q      <= 1'b0;
            done_q      <= 1'b0;
            foreach (seq_q[i]) begin
                seq_q[i] <= '0;
            end
        end else begin
            busy_q <= busy;
            // done set on falling busy, new start drops it
            if (start) begin
                done_q <= 1'b0;
            end else if (busy_q && !busy) begin
                done_q <= 1'b1;
            end
            if (wr && hit_len) begin
                len_q <= pwdata[$bits(len_t)-1:0];
            end
            if (wr && hit_iaddr) begin
                item_addr_q <= pwdata[$bits(item_addr_t)-1:0];
            end
            if (wr && hit_seq) begin
                seq_q[sidx] <= pwdata[$bits(item_addr_t)-1:0];
            end
        end
    end

    // staging buffer, filled word by word
    always_ff @(posedge clk) begin
        if (wr && hit_stage) begin
            stage_q[widx] <= pwdata;
        end
    end

    // read mux, ctrl and commit read as zero
    always_comb begin
        prdata = '0;
        if (hit_status) begin
            prdata = word_t'({done_q, busy});
        end else if (hit_len) begin
            prdata = word_t'(len_q);
        end else if (hit_iaddr) begin
            prdata = word_t'(item_addr_q);
        end else if (hit_seq) begin
            prdata = word_t'(seq_q[sidx]);
        end else if (hit_stage) begin
            prdata = stage_q[widx];
        end else if (hit_result) begin
            prdata = result_words[widx];
        end
    end

    // a job only begins on an accepted start, so a commit never lands inside one
    assert property (@(posedge clk) disable iff (reset)
        $rose(busy) |-> $past(start));

endmodule

/* verilog/hdc_sequencer.sv */
module hdc_sequencer (
    input  logic               clk,
    input  logic               reset,
    input  logic               start,
    input  logic               clear,
    input  logic               last,
    output logic               load,
    output logic               step,
    output logic               rd_en,
    output hdc_pkg::core_cmd_t cmd,
    input  hdc_pkg::rot_t      rot,
    output logic               busy
);
    import hdc_pkg::*;

    seq_state_t state;
    seq_state_t state_next;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start) begin
                    // clear step only when asked for
                    state_next = clear ? CLEAR : FETCH;
                end
            end
            CLEAR: begin
                state_next = FETCH;
            end
            FETCH: begin
                state_next = BIND;
            end
            BIND: begin
                state_next = ACCUM;
            end
            ACCUM: begin
                // last symbol goes to store, else next fetch
                state_next = last ? STORE : FETCH;
            end
            STORE: begin
                state_next = IDLE;
            end
            default: begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign busy  = (state != IDLE);
    // counter loads with the accepted start
    assign load  = start & (state == IDLE);
    // decrement after accum, rot stays stable through bind
    assign step  = (state == ACCUM);
    // ram read issued in fetch, data valid in bind
    assign rd_en = (state == FETCH);

    always_comb begin
        cmd         = '0;
        cmd.rot     = rot;
        cmd.clear   = (state == CLEAR);
        cmd.bind_op = (state == BIND);
        cmd.accum   = (state == ACCUM);
        cmd.store   = (state == STORE);
    end

    // one action per busy cycle, ram read counts as the fetch action
    assert property (@(posedge clk) disable iff (reset)
        busy |-> $onehot({cmd.clear, cmd.bind_op, cmd.accum, cmd.store, rd_en}));

endmodule

/* verilog/hdc_step_counter.sv */
module hdc_step_counter (
    input  logic           clk,
    input  logic           reset,
    input  logic           load,
    input  logic           step,
    input  hdc_pkg::len_t  len,
    output hdc_pkg::slot_t slot,
    output hdc_pkg::rot_t  rot,
    output logic           last
);
    import hdc_pkg::*;

    // symbols still to go, including the current one
    len_t remaining;
    // job length held for the whole run
    len_t len_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            remaining <= '0;
            len_q     <= '0;
        end else if (load) begin
            remaining <= len;
            len_q     <= len;
        end else if (step && remaining != '0) begin
            remaining <= remaining - 1'b1;
        end
    end

    // symbol k = len - remaining
    assign slot = slot_t'(len_q - remaining);
    // rotate by len-1-k
    assign rot  = rot_t'(remaining - len_t'(1));
    assign last = (remaining == len_t'(1));

endmodule

/* verilog/item_memory.sv */
module item_memory #(
    parameter int HV_BITS    = hdc_pkg::HV_BITS_DEF,
    parameter int ITEM_DEPTH = hdc_pkg::ITEM_DEPTH_DEF
) (
    input  logic                clk,
    input  logic                we,
    input  hdc_pkg::item_addr_t waddr,
    input  hdc_pkg::item_addr_t raddr,
    input  logic [HV_BITS-1:0]  wdata,
    input  logic                rd_en,
    output logic [HV_BITS-1:0]  rdata
);

    // one item hypervector per entry, block ram
    logic [HV_BITS-1:0] mem [ITEM_DEPTH];

    // single port use, write from apb, read from sequencer
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        // registered read, one cycle latency
        if (rd_en) begin
            rdata <= mem[raddr];
        end
    end

    // apb commit is refused while the sequencer reads
    assert property (@(posedge clk) we |-> !rd_en);

    // item index programmed by software must exist
    assert property (@(posedge clk) we |-> (int'(waddr) < ITEM_DEPTH));

endmodule

/* verilog/hv_encoder_core.sv */
module hv_encoder_core #(
    parameter int HV_BITS = hdc_pkg::HV_BITS_DEF
) (
    input  logic               clk,
    input  logic               reset,
    input  hdc_pkg::core_cmd_t cmd,
    input  logic [HV_BITS-1:0] item,
    output logic [HV_BITS-1:0] result
);

    typedef logic [HV_BITS-1:0] hv_t;

    hv_t                  bind_q;
    hv_t                  acc_q;
    hv_t                  result_q;
    hv_t                  item_rot;
    logic [2*HV_BITS-1:0] item_pair;

    // rotate right, bit i takes item[(i + rot) mod HV_BITS]
    assign item_pair = {item, item};
    assign item_rot  = hv_t'(item_pair >> cmd.rot);

    // bind register
    always_ff @(posedge clk) begin
        if (cmd.clear) begin
            bind_q <= '0;
        end else if (cmd.bind_op) begin
            bind_q <= item_rot;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            acc_q    <= '0;
            result_q <= '0;
        end else begin
            // without clear the new n-gram bundles onto the old one
            if (cmd.clear) begin
                acc_q <= '0;
            end else if (cmd.accum) begin
                acc_q <= acc_q ^ bind_q;
            end
            if (cmd.store) begin
                result_q <= acc_q;
            end
        end
    end

    assign result = result_q;

    // bind always followed by accum
    assert property (@(posedge clk) disable iff (reset)
        cmd.bind_op |=> cmd.accum);

endmodule

/* verilog/hdc_top.sv */
module hdc_top #(
    parameter int HV_BITS    = hdc_pkg::HV_BITS_DEF,
    parameter int ITEM_DEPTH = hdc_pkg::ITEM_DEPTH_DEF
) (
    input  logic           clk,
    input  logic           reset,
    input  logic           psel,
    input  logic           penable,
    input  logic           pwrite,
    input  logic [11:0]    paddr,
    input  hdc_pkg::word_t pwdata,
    output hdc_pkg::word_t prdata,
    output logic           pready,
    output logic           pslverr
);
    import hdc_pkg::*;

    logic               start;
    logic               clear;
    len_t               len;
    slot_t              slot;
    rot_t               rot;
    logic               last;
    logic               load;
    logic               step;
    logic               rd_en;
    logic               busy;
    core_cmd_t          cmd;
    item_addr_t         seq_addr;
    logic               item_we;
    item_addr_t         item_waddr;
    logic [HV_BITS-1:0] item_wdata;
    logic [HV_BITS-1:0] item_rdata;
    logic [HV_BITS-1:0] result;

    hdc_apb_regs #(
        .HV_BITS (HV_BITS)
    ) u_regs (
        .clk        (clk),
        .reset      (reset),
        .psel       (psel),
        .penable    (penable),
        .pwrite     (pwrite),
        .paddr      (paddr),
        .pwdata     (pwdata),
        .prdata     (prdata),
        .pready     (pready),
        .pslverr    (pslverr),
        .busy       (busy),
        .start      (start),
        .clear      (clear),
        .len        (len),
        .slot       (slot),
        .seq_addr   (seq_addr),
        .item_we    (item_we),
        .item_waddr (item_waddr),
        .item_wdata (item_wdata),
        .result     (result)
    );

    hdc_sequencer u_seq (
        .clk   (clk),
        .reset (reset),
        .start (start),
        .clear (clear),
        .last  (last),
        .load  (load),
        .step  (step),
        .rd_en (rd_en),
        .cmd   (cmd),
        .rot   (rot),
        .busy  (busy)
    );

    hdc_step_counter u_cnt (
        .clk   (clk),
        .reset (reset),
        .load  (load),
        .step  (step),
        .len   (len),
        .slot  (slot),
        .rot   (rot),
        .last  (last)
    );

    item_memory #(
        .HV_BITS    (HV_BITS),
        .ITEM_DEPTH (ITEM_DEPTH)
    ) u_mem (
        .clk   (clk),
        .we    (item_we),
        .waddr (item_waddr),
        .raddr (seq_addr),
        .wdata (item_wdata),
        .rd_en (rd_en),
        .rdata (item_rdata)
    );

    hv_encoder_core #(
        .HV_BITS (HV_BITS)
    ) u_core (
        .clk    (clk),
        .reset  (reset),
        .cmd    (cmd),
        .item   (item_rdata),
        .result (result)
    );

endmodule

/* tests/hdc_model.svh */
`ifndef HDC_MODEL_SVH
`define HDC_MODEL_SVH

// xorshift state, fixed seed
word_t rng_state = 32'h185a;
// reference copy of the loaded items
hv_t   model_items [NUM_ITEMS];
// expected accumulator, follows accepted jobs only
hv_t   model_acc = '0;
int    seq_model [MAX_SYMBOLS];
int    errors = 0;
int    checks = 0;

function automatic word_t next_rand();
    word_t x;
    x = rng_state;
    x ^= x << 13;
    x ^= x >> 17;
    x ^= x << 5;
    rng_state = x;
    return x;
endfunction

function automatic hv_t rand_hv();
    hv_t v;
    for (int i = 0; i < HV_WORDS; i++) begin
        v[32*i +: 32] = next_rand();
    end
    return v;
endfunction

// rotate right by r, low bits wrap to the top
function automatic hv_t rotr(input hv_t x, input int r);
    if (r == 0) begin
        return x;
    end
    return (x >> r) | (x << (HV_BITS - r));
endfunction

// symbol k moves right by len-1-k before the xor
function automatic hv_t model_ngram(input int len);
    hv_t v;
    v = '0;
    for (int k = 0; k < len; k++) begin
        v ^= rotr(model_items[seq_model[k]], len - 1 - k);
    end
    return v;
endfunction

task automatic check_word(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %s: expected %h, actual %h", name, exp, act);
    end
endtask

task automatic check_pslverr(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %s: expected pslverr %b, actual %b", name, exp, act);
    end
endtask

task automatic check_ready(input string name, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %s: expected pready %b, actual %b", name, exp, act);
    end
endtask

task automatic check_status(input string name, input word_t exp, input word_t act);
    checks++;
    if (act !== exp) begin
        errors++;
        $display("[ERROR] %s: expected status %h, actual %h", name, exp, act);
    end
endtask

`endif

/* tests/hdc_tb.sv */
module hdc_tb;
    timeunit 1ns;
    timeprecision 1ns;
    import hdc_pkg::*;

    localparam int HV_BITS    = 256;
    localparam int ITEM_DEPTH = 64;
    localparam int HV_WORDS   = HV_BITS / 32;
    // only the first items get loaded
    localparam int NUM_ITEMS  = 16;
    localparam int NUM_JOBS   = 25;
    localparam int MAX_CYCLES = NUM_JOBS * 30 + 2000;

    typedef logic [HV_BITS-1:0] hv_t;

    logic        clk = 1'b0;
    logic        reset = 1'b1;
    logic        psel = 1'b0;
    logic        penable = 1'b0;
    logic        pwrite = 1'b0;
    logic [11:0] paddr = '0;
    word_t       pwdata = '0;
    word_t       prdata;
    logic        pready;
    logic        pslverr;
    int          cycles = 0;
    int          tests = 0;
    int          err_mark = 0;

    `include "hdc_model.svh"

    hdc_top #(
        .HV_BITS    (HV_BITS),
        .ITEM_DEPTH (ITEM_DEPTH)
    ) dut (
        .clk     (clk),
        .reset   (reset),
        .psel    (psel),
        .penable (penable),
        .pwrite  (pwrite),
        .paddr   (paddr),
        .pwdata  (pwdata),
        .prdata  (prdata),
        .pready  (pready),
        .pslverr (pslverr)
    );

    // 40 ns period
    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: run still going after %0d cycles", cycles);
            $display("Test failed");
            $finish;
        end
    end

    // setup, access, then idle; response sampled mid access cycle
    task automatic apb_xfer(input logic wr, input logic [11:0] addr, input word_t data,
                            output word_t rd, output logic err);
        logic rdy;
        @(posedge clk);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= data;
        @(posedge clk);
        penable <= 1'b1;
        @(negedge clk);
        rd  = prdata;
        err = pslverr;
        rdy = pready;
        @(posedge clk);
        psel    <= 1'b0;
        penable <= 1'b0;
        pwrite  <= 1'b0;
        // zero wait states, ready in every access cycle
        check_ready($sformatf("pready %h", addr), 1'b1, rdy);
    endtask

    task automatic write_reg(input logic [11:0] addr, input word_t data);
        word_t rd;
        logic  err;
        apb_xfer(1'b1, addr, data, rd, err);
        check_pslverr($sformatf("write %h", addr), 1'b0, err);
    endtask

    task automatic read_reg(input logic [11:0] addr, output word_t data);
        logic err;
        apb_xfer(1'b0, addr, '0, data, err);
        check_pslverr($sformatf("read %h", addr), 1'b0, err);
    endtask

    task automatic fill_stage(input hv_t value);
        for (int i = 0; i < HV_WORDS; i++) begin
            write_reg(ADDR_STAGE_BASE + 12'(4 * i), value[32*i +: 32]);
        end
    endtask

    task automatic load_item(input int idx, input hv_t value);
        fill_stage(value);
        write_reg(ADDR_ITEM_ADDR, word_t'(idx));
        write_reg(ADDR_ITEM_COMMIT, 32'h1);
        model_items[idx] = value;
    endtask

    // program len and slots, then start; model follows the accepted job
    task automatic start_job(input int len, input logic clr);
        hv_t ngram;
        write_reg(ADDR_LEN, word_t'(len));
        for (int k = 0; k < len; k++) begin
            write_reg(ADDR_SEQ_BASE + 12'(4 * k), word_t'(seq_model[k]));
        end
        write_reg(ADDR_CTRL, clr ? 32'h3 : 32'h1);
        ngram     = model_ngram(len);
        model_acc = clr ? ngram : (model_acc ^ ngram);
    endtask

    task automatic check_result(input string name);
        word_t rd;
        for (int i = 0; i < HV_WORDS; i++) begin
            read_reg(ADDR_RESULT_BASE + 12'(4 * i), rd);
            check_word($sformatf("%s word %0d", name, i), model_acc[32*i +: 32], rd);
        end
    endtask

    // poll done, the cycle counter catches a hung job
    task automatic finish_job(input string name);
        word_t st;
        st = '0;
        while (!st[1]) begin
            read_reg(ADDR_STATUS, st);
        end
        check_status({name, " status"}, 32'h2, st);
        check_result(name);
    endtask

    task automatic end_test(input string name);
        tests++;
        if (errors == err_mark) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, errors - err_mark);
        end
        err_mark = errors;
    endtask

    initial begin
        word_t rd;
        logic  err;
        int    len;
        int    victim;
        repeat (2) @(posedge clk);
        reset <= 1'b0;

        // 1: reset values
        read_reg(ADDR_STATUS, rd);
        check_status("reset status", 32'h0, rd);
        check_result("reset result");
        end_test("test 1 reset values");

        // 2: single symbol gives the item itself
        for (int i = 0; i < NUM_ITEMS; i++) begin
            load_item(i, rand_hv());
        end
        seq_model[0] = int'(next_rand() % NUM_ITEMS);
        start_job(1, 1'b1);
        finish_job("single symbol");
        end_test("test 2 single symbol");

        // 3: random n-grams, repeats allowed
        for (int j = 0; j < 20; j++) begin
            len = int'(next_rand() % MAX_SYMBOLS) + 1;
            for (int k = 0; k < len; k++) begin
                seq_model[k] = int'(next_rand() % NUM_ITEMS);
            end
            start_job(len, 1'b1);
            finish_job($sformatf("random job %0d", j));
        end
        end_test("test 3 random jobs");

        // 4: bundle onto the previous result
        len = int'(next_rand() % MAX_SYMBOLS) + 1;
        for (int k = 0; k < len; k++) begin
            seq_model[k] = int'(next_rand() % NUM_ITEMS);
        end
        start_job(len, 1'b0);
        finish_job("bundle job");
        end_test("test 4 bundling");

        // 5: refused accesses while busy
        victim = int'(next_rand() % NUM_ITEMS);
        fill_stage(rand_hv());
        write_reg(ADDR_ITEM_ADDR, word_t'(victim));
        for (int k = 0; k < MAX_SYMBOLS; k++) begin
            seq_model[k] = int'(next_rand() % NUM_ITEMS);
        end
        start_job(MAX_SYMBOLS, 1'b1);
        apb_xfer(1'b1, ADDR_ITEM_COMMIT, 32'h1, rd, err);
        check_pslverr("commit while busy", 1'b1, err);
        apb_xfer(1'b1, ADDR_CTRL, 32'h3, rd, err);
        check_pslverr("start while busy", 1'b1, err);
        apb_xfer(1'b0, 12'h050, '0, rd, err);
        check_pslverr("unmapped read", 1'b1, err);
        finish_job("error job");
        // old item still in place
        seq_model[0] = victim;
        start_job(1, 1'b1);
        finish_job("old item");
        end_test("test 5 error responses");

        // 6: overwritten item shows up in the next job
        victim = int'(next_rand() % NUM_ITEMS);
        load_item(victim, rand_hv());
        seq_model[0] = victim;
        seq_model[1] = int'(next_rand() % NUM_ITEMS);
        seq_model[2] = victim;
        start_job(3, 1'b1);
        finish_job("new item");
        end_test("test 6 item overwrite");

        $display("summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* flist.f */
+incdir+tests
verilog/hdc_pkg.sv
verilog/hdc_apb_regs.sv
verilog/hdc_sequencer.sv
verilog/hdc_step_counter.sv
verilog/item_memory.sv
verilog/hv_encoder_core.sv
verilog/hdc_top.sv
tests/hdc_tb.sv
